/* design/memctl_pkg.sv */
// shared address map, register offsets, widths and state types for the memory controller
package memctl_pkg;

   localparam int WORD_W = 32;
   localparam int BE_W   = WORD_W / 8;

   typedef logic [WORD_W-1:0] word_t;
   typedef logic [BE_W-1:0]   be_t;       // bit n enables byte n

   localparam word_t SEG_MASK   = 32'h1FFF_FFFF;  // drops kuseg/kseg0/kseg1 bits

   localparam word_t RAM_BASE   = 32'h0000_0000;
   localparam word_t RAM_WINDOW = 32'h0020_0000;  // 2 MB, ram mirrors inside it
   localparam word_t SCR_BASE   = 32'h1F80_0000;
   localparam word_t SCR_WINDOW = 32'h0000_0400;  // 1 KB scratchpad

   localparam word_t DMA_MADR_ADDR = 32'h1F80_10E0;  // ordering table channel
   localparam word_t DMA_BCR_ADDR  = 32'h1F80_10E4;
   localparam word_t DMA_CHCR_ADDR = 32'h1F80_10E8;

   localparam int    CHCR_START_BIT = 24;
   localparam word_t OTC_END_MARK   = 32'h00FF_FFFF;
   localparam word_t OTC_LINK_MASK  = 32'h00FF_FFFF;

   localparam int DEF_RAM_AW = 10;  // 4 KB of on-chip ram
   localparam int DEF_SCR_AW = 8;   // 256 words

   typedef enum logic [1:0] {
      IDLE,
      ISSUE,
      WAIT,
      RESPOND
   } arb_state_t;

   typedef enum logic [1:0] {SRC_DMA, SRC_DATA, SRC_INST} req_src_t;

   typedef enum logic [1:0] {REG_RAM, REG_SCR, REG_DMA, REG_NONE} region_t;

   typedef enum logic [1:0] {SEL_MADR, SEL_BCR, SEL_CHCR} dma_sel_t;

endpackage

/* design/byte_ram.sv */
// single-port word ram with byte-lane writes and registered read, used for main ram and scratchpad
module byte_ram #(
   parameter int AW = memctl_pkg::DEF_RAM_AW
) (
   input  logic              clk,
   input  logic              en_i,
   input  logic              we_i,
   input  memctl_pkg::be_t   be_i,
   input  logic [AW-1:0]     addr_i,
   input  memctl_pkg::word_t wdata_i,
   output memctl_pkg::word_t rdata_o
);
   import memctl_pkg::*;

   word_t mem [2**AW];

   always_ff @(posedge clk) begin
      if (en_i) begin
         if (we_i) begin
            for (int b = 0; b < BE_W; b++) begin
               if (be_i[b]) begin
                  mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
               end
            end
         end
         rdata_o <= mem[addr_i];   // old word on a write
      end
   end

endmodule

/* design/otc_dma.sv */
// ordering table clear dma channel, holds madr/bcr/chcr and writes the linked list through the arbiter
module otc_dma (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 reg_stb_i,
   input  logic                 reg_we_i,
   input  memctl_pkg::dma_sel_t reg_sel_i,
   input  memctl_pkg::word_t    reg_wdata_i,
   output memctl_pkg::word_t    reg_rdata_o,
   output logic                 dma_req_o,
   output memctl_pkg::word_t    dma_addr_o,
   output memctl_pkg::word_t    dma_wdata_o,
   input  logic                 dma_ack_i
);
   import memctl_pkg::*;

   logic [23:0] madr_q;     // table top, kept as programmed
   logic [15:0] bcr_q;      // entry count
   logic        busy_q;
   logic [15:0] remain_q;
   logic [23:0] cur_q;      // entry being written

   logic  reg_wr;
   logic  start;
   word_t cur_word;
   word_t next_link;

   assign reg_wr = reg_stb_i && reg_we_i;
   assign start  = reg_wr && (reg_sel_i == SEL_CHCR) && reg_wdata_i[CHCR_START_BIT]
                   && (bcr_q != 16'd0) && !busy_q;

   assign cur_word  = {8'h00, cur_q};
   assign next_link = (cur_word - 32'd4) & OTC_LINK_MASK;   // points at entry below

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         madr_q <= '0;
         bcr_q  <= '0;
      end else if (reg_wr) begin
         if (reg_sel_i == SEL_MADR) begin
            madr_q <= reg_wdata_i[23:0];
         end
         if (reg_sel_i == SEL_BCR) begin
            bcr_q <= reg_wdata_i[15:0];
         end
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         busy_q   <= 1'b0;
         remain_q <= '0;
         cur_q    <= '0;
      end else if (start) begin
         busy_q   <= 1'b1;
         remain_q <= bcr_q;
         cur_q    <= madr_q;
      end else if (busy_q && dma_ack_i) begin
         remain_q <= remain_q - 16'd1;
         cur_q    <= cur_q - 24'd4;   // list is built downward
         if (remain_q == 16'd1) begin
            busy_q <= 1'b0;   // that was the end marker
         end
      end
   end

   assign dma_req_o   = busy_q;
   assign dma_addr_o  = cur_word;
   assign dma_wdata_o = (remain_q == 16'd1) ? OTC_END_MARK : next_link;

   // register read, data returned the cycle after the strobe
   always_ff @(posedge clk) begin
      if (reg_stb_i) begin
         case (reg_sel_i)
            SEL_MADR: reg_rdata_o <= {8'h00, madr_q};
            SEL_BCR:  reg_rdata_o <= {16'h0000, bcr_q};
            default:  reg_rdata_o <= word_t'(busy_q) << CHCR_START_BIT;   // start bit = busy
         endcase
      end
   end

endmodule

/* design/addr_decoder.sv */
// address decoder, routes one access to main ram, scratchpad or otc registers with one cycle latency
module addr_decoder #(
   parameter int RAM_AW = memctl_pkg::DEF_RAM_AW,
   parameter int SCR_AW = memctl_pkg::DEF_SCR_AW
) (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 acc_stb_i,
   input  logic                 acc_we_i,
   input  memctl_pkg::be_t      acc_be_i,
   input  memctl_pkg::word_t    acc_addr_i,
   input  memctl_pkg::word_t    acc_wdata_i,
   output logic                 acc_done_o,
   output memctl_pkg::word_t    acc_rdata_o,
   output logic                 ram_en_o,
   output logic                 ram_we_o,
   output memctl_pkg::be_t      ram_be_o,
   output logic [RAM_AW-1:0]    ram_addr_o,
   output memctl_pkg::word_t    ram_wdata_o,
   input  memctl_pkg::word_t    ram_rdata_i,
   output logic                 scr_en_o,
   output logic                 scr_we_o,
   output logic [SCR_AW-1:0]    scr_addr_o,
   input  memctl_pkg::word_t    scr_rdata_i,
   output logic                 reg_stb_o,
   output logic                 reg_we_o,
   output memctl_pkg::dma_sel_t reg_sel_o,
   output memctl_pkg::word_t    reg_wdata_o,
   input  memctl_pkg::word_t    reg_rdata_i
);
   import memctl_pkg::*;

   word_t   phys;
   region_t region;
   region_t region_q;   // steers the return mux a cycle later

   assign phys = acc_addr_i & SEG_MASK;

   always_comb begin
      region    = REG_NONE;
      reg_sel_o = SEL_MADR;
      if ((phys - RAM_BASE) < RAM_WINDOW) begin
         region = REG_RAM;
      end else if ((phys - SCR_BASE) < SCR_WINDOW) begin
         region = REG_SCR;
      end else if (phys[31:2] == DMA_MADR_ADDR[31:2]) begin
         region = REG_DMA;
      end else if (phys[31:2] == DMA_BCR_ADDR[31:2]) begin
         region    = REG_DMA;
         reg_sel_o = SEL_BCR;
      end else if (phys[31:2] == DMA_CHCR_ADDR[31:2]) begin
         region    = REG_DMA;
         reg_sel_o = SEL_CHCR;
      end
   end

   assign ram_en_o    = acc_stb_i && (region == REG_RAM);
   assign ram_we_o    = ram_en_o && acc_we_i;
   assign ram_be_o    = acc_be_i;
   assign ram_addr_o  = phys[RAM_AW+1:2];   // upper bits dropped, ram mirrors
   assign ram_wdata_o = acc_wdata_i;

   assign scr_en_o   = acc_stb_i && (region == REG_SCR);
   assign scr_we_o   = scr_en_o && acc_we_i;
   assign scr_addr_o = phys[SCR_AW+1:2];

   assign reg_stb_o   = acc_stb_i && (region == REG_DMA);
   assign reg_we_o    = reg_stb_o && acc_we_i;
   assign reg_wdata_o = acc_wdata_i;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         acc_done_o <= 1'b0;
         region_q   <= REG_NONE;
      end else begin
         acc_done_o <= acc_stb_i;   // every access acked, mapped or not
         if (acc_stb_i) begin
            region_q <= region;
         end
      end
   end

   always_comb begin
      case (region_q)
         REG_RAM: acc_rdata_o = ram_rdata_i;
         REG_SCR: acc_rdata_o = scr_rdata_i;
         REG_DMA: acc_rdata_o = reg_rdata_i;
         default: acc_rdata_o = '0;   // unmapped reads as zero
      endcase
   end

endmodule

/* design/port_arbiter.sv */
// arbiter for dma, cpu data and cpu instruction requests, one access at a time to the decoder
module port_arbiter (
   input  logic              clk,
   input  logic              rst,
   input  memctl_pkg::word_t data_addr_i,
   input  memctl_pkg::word_t data_wdata_i,
   input  logic              data_ren_i,
   input  memctl_pkg::be_t   data_wen_i,
   output logic              data_ack_o,
   output memctl_pkg::word_t data_rdata_o,
   input  memctl_pkg::word_t inst_addr_i,
   input  logic              inst_ren_i,
   output logic              inst_ack_o,
   output memctl_pkg::word_t inst_rdata_o,
   input  logic              dma_req_i,
   input  memctl_pkg::word_t dma_addr_i,
   input  memctl_pkg::word_t dma_wdata_i,
   output logic              dma_ack_o,
   output logic              acc_stb_o,
   output logic              acc_we_o,
   output memctl_pkg::be_t   acc_be_o,
   output memctl_pkg::word_t acc_addr_o,
   output memctl_pkg::word_t acc_wdata_o,
   input  logic              acc_done_i,
   input  memctl_pkg::word_t acc_rdata_i
);
   import memctl_pkg::*;

   arb_state_t state_q;
   req_src_t   src_q;          // requester currently granted
   logic       we_q;
   logic       skip_q;         // one cpu turn owed after a dma word
   be_t        be_q;
   word_t      addr_q;
   word_t      wdata_q;
   word_t      data_rdata_q;
   word_t      inst_rdata_q;

   logic data_pend;
   logic inst_pend;
   logic grant_dma;
   logic grant_data;
   logic grant_inst;
   logic req_dropped;

   assign data_pend = data_ren_i | (|data_wen_i);
   assign inst_pend = inst_ren_i;

   // fixed priority, dma held back while skip is set
   assign grant_dma  = dma_req_i && !skip_q;
   assign grant_data = !grant_dma && data_pend;
   assign grant_inst = !grant_dma && !data_pend && inst_pend;

   assign req_dropped = (src_q == SRC_INST) ? !inst_pend : !data_pend;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state_q <= IDLE;
         src_q   <= SRC_DATA;
         we_q    <= 1'b0;
         skip_q  <= 1'b0;
      end else begin
         case (state_q)
            IDLE: begin
               if (grant_dma) begin
                  state_q <= ISSUE;
                  src_q   <= SRC_DMA;
                  we_q    <= 1'b1;   // otc only ever writes
                  skip_q  <= 1'b1;
               end else if (grant_data) begin
                  state_q <= ISSUE;
                  src_q   <= SRC_DATA;
                  we_q    <= !data_ren_i;   // read wins if both are up
               end else if (grant_inst) begin
                  state_q <= ISSUE;
                  src_q   <= SRC_INST;
                  we_q    <= 1'b0;
               end else begin
                  skip_q <= 1'b0;   // no cpu waiting, let dma go next time
               end
            end
            ISSUE: begin
               state_q <= WAIT;
            end
            WAIT: begin
               if (acc_done_i) begin
                  state_q <= (src_q == SRC_DMA) ? IDLE : RESPOND;
               end
            end
            RESPOND: begin
               // ack held until the cpu lets go of the request
               if (req_dropped) begin
                  state_q <= IDLE;
                  skip_q  <= 1'b0;
               end
            end
            default: begin
               state_q <= IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state_q == IDLE) begin
         if (grant_dma) begin
            addr_q  <= dma_addr_i;
            wdata_q <= dma_wdata_i;
            be_q    <= 4'hF;
         end else if (grant_data) begin
            addr_q  <= data_addr_i;
            wdata_q <= data_wdata_i;
            be_q    <= data_ren_i ? 4'hF : data_wen_i;
         end else if (grant_inst) begin
            addr_q <= inst_addr_i;
            be_q   <= 4'hF;
         end
      end
      if (state_q == WAIT && acc_done_i && !we_q) begin
         if (src_q == SRC_DATA) begin
            data_rdata_q <= acc_rdata_i;
         end
         if (src_q == SRC_INST) begin
            inst_rdata_q <= acc_rdata_i;
         end
      end
   end

   assign acc_stb_o   = (state_q == ISSUE);
   assign acc_we_o    = we_q;
   assign acc_be_o    = be_q;
   assign acc_addr_o  = addr_q;
   assign acc_wdata_o = wdata_q;

   assign dma_ack_o  = (state_q == WAIT) && acc_done_i && (src_q == SRC_DMA);
   assign data_ack_o = (state_q == RESPOND) && (src_q == SRC_DATA);
   assign inst_ack_o = (state_q == RESPOND) && (src_q == SRC_INST);

   assign data_rdata_o = data_rdata_q;
   assign inst_rdata_o = inst_rdata_q;

endmodule

/* design/mem_controller.sv */
// memory controller top level, instantiate with the cpu data and instruction ports attached
module mem_controller #(
   parameter int RAM_AW = memctl_pkg::DEF_RAM_AW,
   parameter int SCR_AW = memctl_pkg::DEF_SCR_AW
) (
   input  logic              clk,
   input  logic              rst,
   // cpu data port
   input  memctl_pkg::word_t data_addr_i,
   input  memctl_pkg::word_t data_wdata_i,
   input  logic              data_ren_i,
   input  memctl_pkg::be_t   data_wen_i,
   output logic              data_ack_o,
   output memctl_pkg::word_t data_rdata_o,
   // cpu instruction port
   input  memctl_pkg::word_t inst_addr_i,
   input  logic              inst_ren_i,
   output logic              inst_ack_o,
   output memctl_pkg::word_t inst_rdata_o
);
   import memctl_pkg::*;

   logic        dma_req;    // otc channel to arbiter
   word_t       dma_addr;
   word_t       dma_wdata;
   logic        dma_ack;

   logic        acc_stb;    // arbiter to decoder
   logic        acc_we;
   be_t         acc_be;
   word_t       acc_addr;
   word_t       acc_wdata;
   logic        acc_done;
   word_t       acc_rdata;

   logic              ram_en;
   logic              ram_we;
   be_t               ram_be;
   logic [RAM_AW-1:0] ram_addr;
   word_t             ram_wdata;
   word_t             ram_rdata;

   logic              scr_en;
   logic              scr_we;
   logic [SCR_AW-1:0] scr_addr;
   word_t             scr_rdata;

   logic        reg_stb;
   logic        reg_we;
   dma_sel_t    reg_sel;
   word_t       reg_wdata;
   word_t       reg_rdata;

   port_arbiter u_arbiter (
      .clk          (clk),
      .rst          (rst),
      .data_addr_i  (data_addr_i),
      .data_wdata_i (data_wdata_i),
      .data_ren_i   (data_ren_i),
      .data_wen_i   (data_wen_i),
      .data_ack_o   (data_ack_o),
      .data_rdata_o (data_rdata_o),
      .inst_addr_i  (inst_addr_i),
      .inst_ren_i   (inst_ren_i),
      .inst_ack_o   (inst_ack_o),
      .inst_rdata_o (inst_rdata_o),
      .dma_req_i    (dma_req),
      .dma_addr_i   (dma_addr),
      .dma_wdata_i  (dma_wdata),
      .dma_ack_o    (dma_ack),
      .acc_stb_o    (acc_stb),
      .acc_we_o     (acc_we),
      .acc_be_o     (acc_be),
      .acc_addr_o   (acc_addr),
      .acc_wdata_o  (acc_wdata),
      .acc_done_i   (acc_done),
      .acc_rdata_i  (acc_rdata)
   );

   addr_decoder #(.RAM_AW(RAM_AW), .SCR_AW(SCR_AW)) u_decoder (
      .clk         (clk),
      .rst         (rst),
      .acc_stb_i   (acc_stb),
      .acc_we_i    (acc_we),
      .acc_be_i    (acc_be),
      .acc_addr_i  (acc_addr),
      .acc_wdata_i (acc_wdata),
      .acc_done_o  (acc_done),
      .acc_rdata_o (acc_rdata),
      .ram_en_o    (ram_en),
      .ram_we_o    (ram_we),
      .ram_be_o    (ram_be),
      .ram_addr_o  (ram_addr),
      .ram_wdata_o (ram_wdata),
      .ram_rdata_i (ram_rdata),
      .scr_en_o    (scr_en),
      .scr_we_o    (scr_we),
      .scr_addr_o  (scr_addr),
      .scr_rdata_i (scr_rdata),
      .reg_stb_o   (reg_stb),
      .reg_we_o    (reg_we),
      .reg_sel_o   (reg_sel),
      .reg_wdata_o (reg_wdata),
      .reg_rdata_i (reg_rdata)
   );

   byte_ram #(.AW(RAM_AW)) u_main_ram (
      .clk     (clk),
      .en_i    (ram_en),
      .we_i    (ram_we),
      .be_i    (ram_be),
      .addr_i  (ram_addr),
      .wdata_i (ram_wdata),
      .rdata_o (ram_rdata)
   );

   byte_ram #(.AW(SCR_AW)) u_scratchpad (   // shares byte lanes and write data with ram
      .clk     (clk),
      .en_i    (scr_en),
      .we_i    (scr_we),
      .be_i    (ram_be),
      .addr_i  (scr_addr),
      .wdata_i (ram_wdata),
      .rdata_o (scr_rdata)
   );

   otc_dma u_otc_dma (
      .clk         (clk),
      .rst         (rst),
      .reg_stb_i   (reg_stb),
      .reg_we_i    (reg_we),
      .reg_sel_i   (reg_sel),
      .reg_wdata_i (reg_wdata),
      .reg_rdata_o (reg_rdata),
      .dma_req_o   (dma_req),
      .dma_addr_o  (dma_addr),
      .dma_wdata_o (dma_wdata),
      .dma_ack_i   (dma_ack)
   );

endmodule

/* test/tb_mem_controller.sv */
// testbench for mem_controller, replays test/mem_stim.txt on the cpu ports and checks each result
module tb_mem_controller;
   import memctl_pkg::*;

   localparam int CLK_PERIOD  = 40;
   localparam int RAM_AW      = 10;
   localparam int SCR_AW      = 8;
   localparam int ACK_LIMIT   = 100;   // cycles allowed for one handshake edge
   localparam int POLL_LIMIT  = 200;
   localparam int LINE_CYCLES = 400;   // watchdog budget per stimulus line

   logic  clk;
   logic  rst;
   word_t data_addr;
   word_t data_wdata;
   logic  data_ren;
   be_t   data_wen;
   logic  data_ack;
   word_t data_rdata;
   word_t inst_addr;
   logic  inst_ren;
   logic  inst_ack;
   word_t inst_rdata;

   word_t ram_model [2**RAM_AW];   // reference copy of main ram
   logic  ram_known [2**RAM_AW];
   word_t scr_model [2**SCR_AW];
   logic  scr_known [2**SCR_AW];

   byte   op_list   [$];
   word_t addr_list [$];
   word_t data_list [$];
   be_t   be_list   [$];
   word_t exp_list  [$];
   int    n_ops = 0;

   mem_controller #(.RAM_AW(RAM_AW), .SCR_AW(SCR_AW)) u_dut (
      .clk          (clk),
      .rst          (rst),
      .data_addr_i  (data_addr),
      .data_wdata_i (data_wdata),
      .data_ren_i   (data_ren),
      .data_wen_i   (data_wen),
      .data_ack_o   (data_ack),
      .data_rdata_o (data_rdata),
      .inst_addr_i  (inst_addr),
      .inst_ren_i   (inst_ren),
      .inst_ack_o   (inst_ack),
      .inst_rdata_o (inst_rdata)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic stop_with_failure(input string why);
      $display("%s", why);
      $display("SOME TESTS FAILED");
      $fatal(1);
   endtask

   // steps on falling edges until the chosen ack reaches the given level
   task automatic wait_ack(input logic inst_port, input logic level);
      int cycles;
      cycles = 0;
      while ((inst_port ? inst_ack : data_ack) !== level) begin
         @(negedge clk);
         cycles++;
         if (cycles > ACK_LIMIT) begin
            stop_with_failure("a cpu port handshake did not complete in time");
         end
      end
   endtask

   task automatic data_access(input word_t addr, input word_t wdata, input be_t be,
                              input logic is_read, output word_t rdata);
      data_addr  = addr;
      data_wdata = wdata;
      data_ren   = is_read;
      data_wen   = is_read ? 4'h0 : be;
      wait_ack(1'b0, 1'b1);
      rdata    = data_rdata;   // valid while ack is high
      data_ren = 1'b0;
      data_wen = 4'h0;
      wait_ack(1'b0, 1'b0);
   endtask

   task automatic inst_access(input word_t addr, output word_t rdata);
      inst_addr = addr;
      inst_ren  = 1'b1;
      wait_ack(1'b1, 1'b1);
      rdata    = inst_rdata;
      inst_ren = 1'b0;
      wait_ack(1'b1, 1'b0);
   endtask

   task automatic model_write(input word_t addr, input word_t wdata, input be_t be);
      word_t phys;
      int    idx;
      phys = addr & SEG_MASK;
      if (phys < RAM_WINDOW) begin
         idx = int'(phys[RAM_AW+1:2]);   // mirrors every 4 KB
         for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
               ram_model[idx][8*b +: 8] = wdata[8*b +: 8];
            end
         end
         ram_known[idx] = ram_known[idx] || (be == 4'hF);
      end else if (phys >= SCR_BASE && phys < SCR_BASE + SCR_WINDOW) begin
         idx = int'(phys[SCR_AW+1:2]);
         for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
               scr_model[idx][8*b +: 8] = wdata[8*b +: 8];
            end
         end
         scr_known[idx] = scr_known[idx] || (be == 4'hF);
      end
   endtask

   task automatic model_read(input word_t addr, output word_t value, output logic known);
      word_t phys;
      phys  = addr & SEG_MASK;
      value = '0;
      known = 1'b1;   // unmapped space reads as zero
      if (phys < RAM_WINDOW) begin
         value = ram_model[phys[RAM_AW+1:2]];
         known = ram_known[phys[RAM_AW+1:2]];
      end else if (phys >= SCR_BASE && phys < SCR_BASE + SCR_WINDOW) begin
         value = scr_model[phys[SCR_AW+1:2]];
         known = scr_known[phys[SCR_AW+1:2]];
      end else if (phys >= DMA_MADR_ADDR && phys < DMA_CHCR_ADDR + 32'd4) begin
         known = 1'b0;   // channel registers are not modelled
      end
   endtask

   task automatic check_read(input word_t addr, input word_t got, input word_t exp_val);
      word_t model;
      logic  known;
      model_read(addr, model, known);
      assert (got === exp_val) else
         stop_with_failure($sformatf("ERROR t=%0t addr=%08h read %08h, expected %08h",
                                     $time, addr, got, exp_val));
      if (known) begin
         assert (got === model) else
            stop_with_failure($sformatf("ERROR t=%0t addr=%08h read %08h, model holds %08h",
                                        $time, addr, got, model));
      end
   endtask

   task automatic poll_dma_idle(input word_t chcr_addr);
      word_t got;
      int    polls;
      polls = 0;
      do begin
         data_access(chcr_addr, '0, 4'hF, 1'b1, got);
         polls++;
         if (polls > POLL_LIMIT) begin
            stop_with_failure("the ordering table channel never went idle");
         end
      end while (got[CHCR_START_BIT]);
   endtask

   // instruction fetches over known words, with random segment and mirror copy
   task automatic random_inst_reads(input word_t base, input int count, input int span);
      word_t addr;
      word_t seg;
      word_t got;
      word_t model;
      logic  known;
      for (int k = 0; k < count; k++) begin
         case ($urandom_range(2, 0))
            0:       seg = 32'h0000_0000;
            1:       seg = 32'h8000_0000;
            default: seg = 32'hA000_0000;
         endcase
         addr = base + 32'd4 * $urandom_range(span - 1, 0);
         addr = seg | (addr + (word_t'($urandom_range(511, 0)) << (RAM_AW + 2)));
         model_read(addr, model, known);
         if (!known) begin
            stop_with_failure("random reads target words the stimulus never wrote");
         end
         inst_access(addr, got);
         assert (got === model) else
            stop_with_failure($sformatf("ERROR t=%0t addr=%08h fetched %08h, model holds %08h",
                                        $time, addr, got, model));
      end
   endtask

   initial begin
      wait (n_ops > 0);
      #(n_ops * LINE_CYCLES * CLK_PERIOD);
      stop_with_failure("watchdog expired before the stimulus was finished");
   end

   initial begin
      int    fd;
      int    n;
      string line;
      byte   op;
      word_t addr;
      word_t data;
      be_t   be;
      word_t exp_val;
      word_t got;

      void'($urandom(32'h344c));
      clk        = 1'b0;
      rst        = 1'b1;
      data_addr  = '0;
      data_wdata = '0;
      data_ren   = 1'b0;
      data_wen   = 4'h0;
      inst_addr  = '0;
      inst_ren   = 1'b0;
      for (int i = 0; i < 2**RAM_AW; i++) begin
         ram_known[i] = 1'b0;
      end
      for (int i = 0; i < 2**SCR_AW; i++) begin
         scr_known[i] = 1'b0;
      end

      fd = $fopen("test/mem_stim.txt", "r");
      if (fd == 0) begin
         stop_with_failure("cannot open the stimulus file test/mem_stim.txt");
      end
      while (!$feof(fd)) begin
         line = "";
         void'($fgets(line, fd));
         if (line.len() == 0 || line[0] == "#") begin
            continue;
         end
         n = $sscanf(line, "%c %h %h %h %h", op, addr, data, be, exp_val);
         if (n == 5) begin
            op_list.push_back(op);
            addr_list.push_back(addr);
            data_list.push_back(data);
            be_list.push_back(be);
            exp_list.push_back(exp_val);
         end
      end
      $fclose(fd);
      n_ops = op_list.size();

      repeat (3) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;

      for (int i = 0; i < n_ops; i++) begin
         case (op_list[i])
            "W": begin
               data_access(addr_list[i], data_list[i], be_list[i], 1'b0, got);
               model_write(addr_list[i], data_list[i], be_list[i]);
            end
            "R": begin
               data_access(addr_list[i], '0, 4'hF, 1'b1, got);
               check_read(addr_list[i], got, exp_list[i]);
            end
            "I": begin
               inst_access(addr_list[i], got);
               check_read(addr_list[i], got, exp_list[i]);
            end
            "P": poll_dma_idle(addr_list[i]);
            "X": random_inst_reads(addr_list[i], int'(data_list[i]), int'(exp_list[i]));
            default: begin
               stop_with_failure($sformatf("unknown operation %c in the stimulus file",
                                           op_list[i]));
            end
         endcase
      end
      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

/* build.f */
design/memctl_pkg.sv
design/byte_ram.sv
design/otc_dma.sv
design/addr_decoder.sv
design/port_arbiter.sv
design/mem_controller.sv
test/tb_mem_controller.sv

/* test/mem_stim.txt */
# columns: op address data byte_enables expected (hex), op is W R I P or X
# X reads data random words from address, spread over expected words; P polls CHCR idle
W 00000010 11223344 f 00000000
W 00000010 aabbccdd 5 00000000
R 00000010 00000000 0 11bb33dd
R 80001010 00000000 0 11bb33dd
W 00001010 0000ee00 2 00000000
R a0100010 00000000 0 11bbeedd
W 1f800010 cafef00d f 00000000
R 1f800010 00000000 0 cafef00d
R 00000010 00000000 0 11bbeedd
R 9f800010 00000000 0 cafef00d
W 1f803000 deadbeef f 00000000
R 1f803000 00000000 0 00000000
R 00200000 00000000 0 00000000
W 00000100 a5a50100 f 00000000
W 80000104 5a5a0104 f 00000000
W a0000108 c3c30108 f 00000000
W 0000010c 3c3c010c f 00000000
I 00000100 00000000 0 a5a50100
I 8000010c 00000000 0 3c3c010c
I 1f802000 00000000 0 00000000
W 1f8010e0 00000800 f 00000000
W 1f8010e4 00000010 f 00000000
W 1f8010e8 01000000 f 00000000
X 00000100 0000000c 0 00000004
P 1f8010e8 00000000 0 00000000
R 1f8010e8 00000000 0 00000000
R 1f8010e0 00000000 0 00000800
R 1f8010e4 00000000 0 00000010
R 00000800 00000000 0 000007fc
R 000007fc 00000000 0 000007f8
R 000007c8 00000000 0 000007c4
R 000007c4 00000000 0 00ffffff
R 80100800 00000000 0 000007fc
I 000007c4 00000000 0 00ffffff
